/* design/md_op_pkg.sv */
// Operation encodings of the multiply/divide unit
// Operand, half-operand and accumulator widths
// Per-operand signedness selection type

package md_op_pkg;

  // Operand and result width of the unit
  localparam int XLEN = 32;

  // Half-operand width seen by the 17x17 multiplier
  localparam int HALF_W = 16;

  // Accumulator width, partial product plus carry and sign
  localparam int MAC_W = 34;

  // Operations of the unit
  typedef enum logic [1:0] {
    // Low word of the product
    MD_OP_MULL,
    // High word of the product
    MD_OP_MULH,
    // Quotient
    MD_OP_DIV,
    // Remainder
    MD_OP_REM
  } md_op_e;

  // Bit 0 marks operand a as signed, bit 1 marks operand b as signed
  typedef logic [1:0] md_sign_t;

endpackage

/* design/md_ctrl_pkg.sv */
// Multiplier phase and divider state encodings
// Bit counter constants of the divide loop

package md_ctrl_pkg;

  // Partial-product phases of the iterative multiplier
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_phase_e;

  // Long division FSM states
  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_CHANGE_SIGN,
    DIV_FINISH
  } div_state_e;

  localparam int DIV_CNT_W = 5;
  localparam logic [DIV_CNT_W-1:0] DIV_FIRST_BIT = 5'd31;

endpackage

/* design/md_ctrl_if.sv */
// Interface between the sequencer and the multiply and divide datapaths
// Carries phase, state, step enables and the result words

`timescale 1ns/1ps

interface md_ctrl_if import md_ctrl_pkg::*; ();

  // Driven by the sequencer
  mult_phase_e                 mult_phase;
  logic                        mult_step;
  div_state_e                  div_state;
  logic [DIV_CNT_W-1:0]        div_count;
  logic                        div_step;

  // Driven by the datapaths
  logic [md_op_pkg::XLEN-1:0]  mac_result;
  logic [md_op_pkg::XLEN-1:0]  div_result;
  logic                        divisor_zero;

  modport ctrl (
    output mult_phase, mult_step, div_state, div_count, div_step,
    input  mac_result, div_result, divisor_zero
  );

  modport mac (
    input  mult_phase, mult_step,
    output mac_result
  );

  modport div (
    input  div_state, div_count, div_step,
    output div_result, divisor_zero
  );

endinterface

/* design/md_controller.sv */
// Multiplier phase sequencer and long division FSM
// Division bit counter, valid generation and result selection

`timescale 1ns/1ps

module md_controller
  import md_op_pkg::*;
  import md_ctrl_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  md_op_e          operator_i,
  md_ctrl_if.ctrl         ctrl,
  output logic [XLEN-1:0] result_o,
  output logic            valid_o
);

  logic                 is_mult;
  logic                 mult_step;
  logic                 div_step;
  logic                 mult_valid;
  logic                 div_valid;
  mult_phase_e          phase_q, phase_d;
  div_state_e           state_q, state_d;
  logic [DIV_CNT_W-1:0] cnt_q, cnt_d;

  assign is_mult   = (operator_i == MD_OP_MULL) || (operator_i == MD_OP_MULH);
  assign mult_step = en_i & is_mult;
  assign div_step  = en_i & ~is_mult;

  // Multiplier phases, MULL ends in AHBL and MULH in AHBH
  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      ALBL: phase_d = ALBH;
      ALBH: phase_d = AHBL;
      AHBL: phase_d = (operator_i == MD_OP_MULL) ? ALBL : AHBH;
      AHBH: phase_d = ALBL;
      default: phase_d = ALBL;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= ALBL;
    end else if (mult_step) begin
      phase_q <= phase_d;
    end
  end

  assign mult_valid = mult_step &
                      (((phase_q == AHBL) && (operator_i == MD_OP_MULL)) ||
                       (phase_q == AHBH));

  // Divider FSM and bit counter
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      DIV_IDLE: begin
        // Division by zero skips the whole loop
        state_d = ctrl.divisor_zero ? DIV_FINISH : DIV_ABS_A;
        cnt_d   = DIV_FIRST_BIT;
      end
      DIV_ABS_A: begin
        state_d = DIV_ABS_B;
        cnt_d   = DIV_FIRST_BIT;
      end
      DIV_ABS_B: begin
        state_d = DIV_COMP;
        cnt_d   = DIV_FIRST_BIT;
      end
      DIV_COMP: begin
        state_d = (cnt_q == DIV_CNT_W'(1)) ? DIV_LAST : DIV_COMP;
        cnt_d   = cnt_q - 1'b1;
      end
      DIV_LAST: begin
        state_d = DIV_CHANGE_SIGN;
      end
      DIV_CHANGE_SIGN: begin
        state_d = DIV_FINISH;
      end
      DIV_FINISH: begin
        state_d = DIV_IDLE;
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else if (div_step) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign div_valid = div_step & (state_q == DIV_FINISH);

  assign ctrl.mult_phase = phase_q;
  assign ctrl.mult_step  = mult_step;
  assign ctrl.div_state  = state_q;
  assign ctrl.div_count  = cnt_q;
  assign ctrl.div_step   = div_step;

  assign valid_o  = mult_valid | div_valid;
  assign result_o = is_mult ? ctrl.mac_result : ctrl.div_result;

  // Divider never leaves the defined state set
  div_state_legal_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST,
                    DIV_CHANGE_SIGN, DIV_FINISH}
  );

  // Operator held until the result is delivered
  operator_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (en_i && !valid_o) |=> $stable(operator_i)
  );

endmodule

/* design/md_mac_datapath.sv */
// Iterative 17x17 signed multiply-accumulate
// Per-phase operand and addend selection, accumulator register

`timescale 1ns/1ps

module md_mac_datapath
  import md_op_pkg::*;
  import md_ctrl_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  md_sign_t        signed_mode_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  md_op_e          operator_i,
  md_ctrl_if.mac          ctrl
);

  logic [HALF_W-1:0]        mul_a;
  logic [HALF_W-1:0]        mul_b;
  logic                     sign_a;
  logic                     sign_b;
  logic                     signed_mult;
  logic [MAC_W-1:0]         addend;
  logic signed [MAC_W-1:0]  mac_res;
  logic [MAC_W-1:0]         acc_q, acc_d;

  assign signed_mult = (signed_mode_i != 2'b00);

  always_comb begin
    mul_a  = op_a_i[HALF_W-1:0];
    mul_b  = op_b_i[HALF_W-1:0];
    sign_a = 1'b0;
    sign_b = 1'b0;
    addend = '0;
    unique case (ctrl.mult_phase)
      ALBH: begin
        mul_b  = op_b_i[XLEN-1:HALF_W];
        sign_b = signed_mode_i[1] & op_b_i[XLEN-1];
        // AL*BL is unsigned, only its upper half carries on
        addend = {{(MAC_W-HALF_W){1'b0}}, acc_q[XLEN-1:HALF_W]};
      end
      AHBL: begin
        mul_a  = op_a_i[XLEN-1:HALF_W];
        sign_a = signed_mode_i[0] & op_a_i[XLEN-1];
        addend = (operator_i == MD_OP_MULL) ?
                 {{(MAC_W-HALF_W){1'b0}}, acc_q[XLEN-1:HALF_W]} : acc_q;
      end
      AHBH: begin
        mul_a  = op_a_i[XLEN-1:HALF_W];
        mul_b  = op_b_i[XLEN-1:HALF_W];
        sign_a = signed_mode_i[0] & op_a_i[XLEN-1];
        sign_b = signed_mode_i[1] & op_b_i[XLEN-1];
        // Upper part weighs 2^32, sign extend when any operand is signed
        addend = {{HALF_W{signed_mult & acc_q[MAC_W-1]}}, acc_q[MAC_W-1:HALF_W]};
      end
      default: begin
        addend = '0;
      end
    endcase
  end

  assign mac_res = $signed({sign_a, mul_a}) * $signed({sign_b, mul_b}) + $signed(addend);

  // Low word keeps AL*BL[15:0] below the new middle bits
  assign acc_d = ((ctrl.mult_phase == ALBH) && (operator_i == MD_OP_MULL)) ?
                 {2'b00, mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]} : mac_res;

  always_ff @(posedge clk_i) begin
    if (ctrl.mult_step) begin
      acc_q <= acc_d;
    end
  end

  assign ctrl.mac_result = (operator_i == MD_OP_MULL) ?
                           {mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]} : mac_res[XLEN-1:0];

  // High word fits 33 bits, so the top two bits agree
  acc_top_sign_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (ctrl.mult_step && ctrl.mult_phase == AHBH) |=> (acc_q[MAC_W-1] == acc_q[MAC_W-2])
  );

endmodule

/* design/md_div_datapath.sv */
// Long division datapath with its own 33-bit subtract adder
// Absolute values, restoring compare loop, sign correction
// Division by zero presets of quotient and remainder

`timescale 1ns/1ps

module md_div_datapath
  import md_op_pkg::*;
  import md_ctrl_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  md_sign_t        signed_mode_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  md_op_e          operator_i,
  md_ctrl_if.div          ctrl
);

  logic [XLEN:0]          add_a;
  logic [XLEN:0]          add_b;
  logic [XLEN:0]          add_res;
  logic                   is_ge;
  logic                   sign_a;
  logic                   sign_b;
  logic                   div_neg;
  logic [DIV_CNT_W-1:0]   bit_idx;
  logic [XLEN-1:0]        next_rem;
  logic [XLEN-1:0]        next_quo;
  logic [XLEN-1:0]        num_q, num_d;
  logic [XLEN-1:0]        den_q, den_d;
  logic [XLEN-1:0]        quo_q, quo_d;
  // Partial remainder, later the final result word
  logic [XLEN:0]          rem_q, rem_d;

  assign sign_a  = signed_mode_i[0] & op_a_i[XLEN-1];
  assign sign_b  = signed_mode_i[1] & op_b_i[XLEN-1];
  assign div_neg = sign_a ^ sign_b;

  // Adder operands per state, default computes 0 - a
  always_comb begin
    add_a = '0;
    add_b = {1'b0, op_a_i};
    unique case (ctrl.div_state)
      DIV_ABS_B: add_b = {1'b0, op_b_i};
      DIV_COMP,
      DIV_LAST: begin
        add_a = rem_q;
        add_b = {1'b0, den_q};
      end
      DIV_CHANGE_SIGN: add_b = rem_q;
      default: add_b = {1'b0, op_a_i};
    endcase
  end

  assign add_res  = add_a - add_b;
  // Remainder minus denominator is non-negative
  assign is_ge    = ~add_res[XLEN];
  assign next_rem = is_ge ? add_res[XLEN-1:0] : rem_q[XLEN-1:0];
  assign bit_idx  = ctrl.div_count - 1'b1;

  always_comb begin
    next_quo = quo_q;
    next_quo[ctrl.div_count] = quo_q[ctrl.div_count] | is_ge;
  end

  always_comb begin
    num_d = num_q;
    den_d = den_q;
    quo_d = quo_q;
    rem_d = rem_q;
    unique case (ctrl.div_state)
      DIV_IDLE: begin
        // Only kept when the divisor is zero
        rem_d = (operator_i == MD_OP_DIV) ? {1'b0, {XLEN{1'b1}}} : {1'b0, op_a_i};
      end
      DIV_ABS_A: begin
        quo_d = '0;
        num_d = sign_a ? add_res[XLEN-1:0] : op_a_i;
      end
      DIV_ABS_B: begin
        rem_d = {{XLEN{1'b0}}, num_q[XLEN-1]};
        den_d = sign_b ? add_res[XLEN-1:0] : op_b_i;
      end
      DIV_COMP: begin
        // Shift in the next numerator bit
        rem_d = {next_rem, num_q[bit_idx]};
        quo_d = next_quo;
      end
      DIV_LAST: begin
        rem_d = (operator_i == MD_OP_DIV) ? {1'b0, next_quo} : {1'b0, next_rem};
      end
      DIV_CHANGE_SIGN: begin
        if ((operator_i == MD_OP_DIV) ? div_neg : sign_a) begin
          rem_d = {1'b0, add_res[XLEN-1:0]};
        end
      end
      default: begin
        rem_d = rem_q;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (ctrl.div_step) begin
      num_q <= num_d;
      den_q <= den_d;
      quo_q <= quo_d;
      rem_q <= rem_d;
    end
  end

  assign ctrl.divisor_zero = (op_b_i == '0);
  assign ctrl.div_result   = rem_q[XLEN-1:0];

  // Restoring step keeps the shifted remainder below 2 * denominator
  rem_bound_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (ctrl.div_step && ctrl.div_state == DIV_COMP) |-> ({1'b0, rem_q} < {1'b0, den_q, 1'b0})
  );

endmodule

/* design/multdiv_top.sv */
// Top level of the multiply/divide unit
// Sequencer, multiply and divide datapaths joined by md_ctrl_if

`timescale 1ns/1ps

module multdiv_top
  import md_op_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  md_op_e          operator_i,
  input  md_sign_t        signed_mode_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            valid_o
);

  md_ctrl_if md_if_i ();

  md_controller ctrl_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .operator_i (operator_i),
    .ctrl       (md_if_i.ctrl),
    .result_o   (result_o),
    .valid_o    (valid_o)
  );

  md_mac_datapath mac_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .operator_i    (operator_i),
    .ctrl          (md_if_i.mac)
  );

  md_div_datapath div_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .operator_i    (operator_i),
    .ctrl          (md_if_i.div)
  );

endmodule

/* sim/tb_ref_model.svh */
// Expected results of the multiply/divide unit
// 64-bit product and RISC-V style quotient and remainder

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Full product with each operand extended by its own signedness
function automatic logic [63:0] ref_product(input logic [1:0] mode,
                                            input logic [31:0] a,
                                            input logic [31:0] b);
  logic [63:0] a_ext;
  logic [63:0] b_ext;
  a_ext = mode[0] ? {{32{a[31]}}, a} : {32'h0, a};
  b_ext = mode[1] ? {{32{b[31]}}, b} : {32'h0, b};
  return a_ext * b_ext;
endfunction

function automatic logic [31:0] ref_quotient(input logic [1:0] mode,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
  if (b == 32'h0) return 32'hFFFF_FFFF;
  if (mode == 2'b11) begin
    // Overflow case wraps to the most negative value
    if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return a;
    return $signed(a) / $signed(b);
  end
  return a / b;
endfunction

function automatic logic [31:0] ref_remainder(input logic [1:0] mode,
                                              input logic [31:0] a,
                                              input logic [31:0] b);
  if (b == 32'h0) return a;
  if (mode == 2'b11) begin
    if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return 32'h0;
    return $signed(a) % $signed(b);
  end
  return a % b;
endfunction

function automatic logic [31:0] ref_result(input md_op_e op, input logic [1:0] mode,
                                           input logic [31:0] a, input logic [31:0] b);
  logic [63:0] product;
  product = ref_product(mode, a, b);
  case (op)
    MD_OP_MULL: return product[31:0];
    MD_OP_MULH: return product[63:32];
    MD_OP_DIV:  return ref_quotient(mode, a, b);
    default:    return ref_remainder(mode, a, b);
  endcase
endfunction

`endif

/* sim/tb_multdiv.sv */
// Testbench of the multiply/divide unit
// Directed multiply, divide, corner and back-to-back tests

`timescale 1ns/1ps

module tb_multdiv import md_op_pkg::*; ();

  `include "tb_ref_model.svh"

  localparam int VALID_TIMEOUT = 50;

  logic            clk_i;
  logic            rst_ni;
  logic            en_i;
  md_op_e          operator_i;
  md_sign_t        signed_mode_i;
  logic [XLEN-1:0] op_a_i;
  logic [XLEN-1:0] op_b_i;
  logic [XLEN-1:0] result_o;
  logic            valid_o;
  logic [31:0]     lcg_state;

  multdiv_top dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Cycle of valid_o counted from the first edge that samples en_i
  function automatic int expected_latency(input md_op_e op, input logic [XLEN-1:0] b);
    if (op == MD_OP_MULL) return 3;
    if (op == MD_OP_MULH) return 4;
    if (b == '0) return 2;
    return 37;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic run_op(input string name, input md_op_e op, input md_sign_t mode,
                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [XLEN-1:0] expected;
    logic [XLEN-1:0] actual;
    int              want_cycles;
    int              cycles;
    expected    = ref_result(op, mode, a, b);
    want_cycles = expected_latency(op, b);
    @(negedge clk_i);
    en_i          = 1'b1;
    operator_i    = op;
    signed_mode_i = mode;
    op_a_i        = a;
    op_b_i        = b;
    // valid_o cannot rise before the first edge that samples en_i
    cycles = 1;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!valid_o && cycles < VALID_TIMEOUT);
    assert (valid_o === 1'b1) else
      stop_on_error($sformatf("Timeout in %s: valid_o never arrived within %0d cycles",
                              name, VALID_TIMEOUT));
    actual = result_o;
    assert (actual === expected) else
      stop_on_error($sformatf("FAIL %s: expected 0x%08h, actual 0x%08h",
                              name, expected, actual));
    assert (cycles == want_cycles) else
      stop_on_error($sformatf("FAIL %s latency: expected %0d cycles, actual %0d cycles",
                              name, want_cycles, cycles));
    // Keep en_i across the valid edge so the unit returns to idle
    @(negedge clk_i);
    en_i = 1'b0;
  endtask

  task automatic test_mull_random();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < 20; i++) begin
      a = next_random();
      b = next_random();
      for (int m = 0; m < 4; m++) begin
        run_op($sformatf("mull pair %0d mode %0d", i, m), MD_OP_MULL, md_sign_t'(m), a, b);
      end
    end
  endtask

  task automatic test_mulh();
    md_sign_t        modes [3];
    logic [XLEN-1:0] corner [2];
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    modes  = '{2'b00, 2'b01, 2'b11};
    corner = '{32'h8000_0000, 32'hFFFF_FFFF};
    foreach (modes[m]) begin
      foreach (corner[i]) begin
        foreach (corner[j]) begin
          run_op($sformatf("mulh corner %0d%0d mode %0d", i, j, modes[m]), MD_OP_MULH,
                 modes[m], corner[i], corner[j]);
        end
      end
      for (int k = 0; k < 6; k++) begin
        a = next_random();
        b = next_random();
        run_op($sformatf("mulh random %0d mode %0d", k, modes[m]), MD_OP_MULH,
               modes[m], a, b);
      end
    end
  endtask

  task automatic test_div_random();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int i = 0; i < 20; i++) begin
      a = next_random() >> (i % 8);
      b = next_random() >> (i % 24);
      if (b == '0) b = 32'd3;
      // Alternate the operand signs over the pairs
      if (i[0]) a = -a;
      if (i[1]) b = -b;
      run_op($sformatf("divu pair %0d", i), MD_OP_DIV, 2'b00, a, b);
      run_op($sformatf("remu pair %0d", i), MD_OP_REM, 2'b00, a, b);
      run_op($sformatf("div pair %0d", i), MD_OP_DIV, 2'b11, a, b);
      run_op($sformatf("rem pair %0d", i), MD_OP_REM, 2'b11, a, b);
    end
  endtask

  task automatic test_div_by_zero();
    logic [XLEN-1:0] dividends [3];
    dividends = '{32'h1234_5678, 32'h8000_0001, 32'h0};
    foreach (dividends[i]) begin
      run_op($sformatf("divu zero %0d", i), MD_OP_DIV, 2'b00, dividends[i], '0);
      run_op($sformatf("remu zero %0d", i), MD_OP_REM, 2'b00, dividends[i], '0);
      run_op($sformatf("div zero %0d", i), MD_OP_DIV, 2'b11, dividends[i], '0);
      run_op($sformatf("rem zero %0d", i), MD_OP_REM, 2'b11, dividends[i], '0);
    end
  endtask

  task automatic test_div_overflow();
    run_op("div overflow", MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF);
    run_op("rem overflow", MD_OP_REM, 2'b11, 32'h8000_0000, 32'hFFFF_FFFF);
  endtask

  // en_i drops for one cycle between the two operations
  task automatic test_back_to_back();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = next_random();
    b = next_random();
    run_op("b2b mulh", MD_OP_MULH, 2'b11, a, b);
    b = (next_random() >> 12) | 32'd1;
    run_op("b2b div", MD_OP_DIV, 2'b11, a, b);
  endtask

  initial begin
    rst_ni        = 1'b0;
    en_i          = 1'b0;
    operator_i    = MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    lcg_state     = 32'd37;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    assert (valid_o === 1'b0) else
      stop_on_error("valid_o is not low after reset");
    test_mull_random();
    test_mulh();
    test_div_random();
    test_div_by_zero();
    test_div_overflow();
    test_back_to_back();
    $display("Done: no errors");
    $finish;
  end

endmodule

/* build.f */
+incdir+sim
design/md_op_pkg.sv
design/md_ctrl_pkg.sv
design/md_ctrl_if.sv
design/md_controller.sv
design/md_mac_datapath.sv
design/md_div_datapath.sv
design/multdiv_top.sv
sim/tb_multdiv.sv

/* Bender.yml */
package:
  name: multdiv

sources:
  - files:
      - design/md_op_pkg.sv
      - design/md_ctrl_pkg.sv
      - design/md_ctrl_if.sv
      - design/md_controller.sv
      - design/md_mac_datapath.sv
      - design/md_div_datapath.sv
      - design/multdiv_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_multdiv.sv
